// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_vector_fixed
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// ==== common/fixed_pkg.sv ====
package fixed_pkg;

  ////////////////////////////////////////
  // Number format
  ////////////////////////////////////////

  // Signed two's-complement word
  localparam int DATA_WIDTH = 32;

  // Full product before the binary point shift
  localparam int PROD_WIDTH = 2 * DATA_WIDTH;

  typedef logic signed [DATA_WIDTH-1:0] word_t;

  ////////////////////////////////////////
  // Saturation limits
  ////////////////////////////////////////

  // Largest positive word
  localparam word_t WORD_MAX = {1'b0, {(DATA_WIDTH - 1) {1'b1}}};

  // Most negative word
  localparam word_t WORD_MIN = {1'b1, {(DATA_WIDTH - 1) {1'b0}}};

  ////////////////////////////////////////
  // Host operand bundle
  ////////////////////////////////////////

  // a_en and b_en strobe independently
  typedef struct packed {
    word_t a;
    logic  a_en;
    word_t b;
    logic  b_en;
  } operand_pair_t;

endpackage

// ==== common/vector_ctrl_pkg.sv ====
package vector_ctrl_pkg;

  ////////////////////////////////////////
  // Controller states
  ////////////////////////////////////////

  // Idle, collecting a pair, waiting on the multiplier
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_INPUT = 2'd1,
    ST_WAIT  = 2'd2
  } ctrl_state_t;

  ////////////////////////////////////////
  // Element result
  ////////////////////////////////////////

  // One product per element
  // Valid is a single-cycle strobe
  // Last marks the final element of a run
  typedef struct packed {
    fixed_pkg::word_t data;
    logic             valid;
    logic             last;
  } elem_result_t;

endpackage

// ==== flist.f ====
common/fixed_pkg.sv
common/vector_ctrl_pkg.sv
hw/scalar_fixed_multiplier.sv
vector_unit/vector_fixed_multiplier.sv
vector_unit/dot_accumulator.sv
hw/vector_fixed_top.sv
sim/tb_vector_fixed.sv

// ==== hw/scalar_fixed_multiplier.sv ====
`timescale 1ns/10ps

module scalar_fixed_multiplier #(
  parameter int FRAC_BITS = 16
) (
  input  logic             CLK,
  input  logic             RST,
  input  logic             start,
  input  fixed_pkg::word_t a,
  input  fixed_pkg::word_t b,
  output logic             ready,
  output fixed_pkg::word_t product
);

  localparam int W  = fixed_pkg::DATA_WIDTH;
  localparam int PW = fixed_pkg::PROD_WIDTH;
  localparam int CW = $clog2(W);

  // Final shift-add step index
  localparam logic [CW-1:0] LAST_STEP = CW'(W - 1);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  logic          busy;
  logic [CW-1:0] step_cnt;

  // Operand magnitudes and running sum
  logic [ W-1:0] abs_a;
  logic [ W-1:0] abs_b;
  logic [PW-1:0] mag_a;
  logic [ W-1:0] mag_b;
  logic [PW-1:0] acc;
  logic [PW-1:0] acc_next;
  logic          neg;

  // Signed, shifted and clamped result
  logic signed [PW-1:0] full_prod;
  logic signed [PW-1:0] shifted;
  fixed_pkg::word_t     sat_prod;

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  // Magnitudes, the most negative word maps to 2^(W-1)
  assign abs_a = a[W-1] ? $unsigned(-a) : $unsigned(a);
  assign abs_b = b[W-1] ? $unsigned(-b) : $unsigned(b);

  // Add the shifted multiplicand when the current multiplier bit is set
  assign acc_next = acc + (mag_b[0] ? mag_a : '0);

  // Sign restored on the completed magnitude
  assign full_prod = neg ? -$signed(acc_next) : $signed(acc_next);

  // Arithmetic shift rounds toward minus infinity
  assign shifted = full_prod >>> FRAC_BITS;

  always_comb begin
    if (shifted > fixed_pkg::WORD_MAX) begin
      sat_prod = fixed_pkg::WORD_MAX;
    end else if (shifted < fixed_pkg::WORD_MIN) begin
      sat_prod = fixed_pkg::WORD_MIN;
    end else begin
      sat_prod = shifted[W-1:0];
    end
  end

  // Operand load and shift-add steps
  always_ff @(posedge CLK) begin
    if (start && !busy) begin
      mag_a <= {{(PW - W) {1'b0}}, abs_a};
      mag_b <= abs_b;
      acc   <= '0;
      neg   <= a[W-1] ^ b[W-1];
    end else if (busy) begin
      mag_a <= mag_a << 1;
      mag_b <= mag_b >> 1;
      acc   <= acc_next;
    end
  end

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  // Load at start, 32 steps, ready with the last step
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy     <= 1'b0;
      step_cnt <= '0;
      ready    <= 1'b0;
      product  <= '0;
    end else begin
      ready <= 1'b0;
      if (start && !busy) begin
        busy     <= 1'b1;
        step_cnt <= '0;
      end else if (busy) begin
        step_cnt <= step_cnt + 1'b1;
        if (step_cnt == LAST_STEP) begin
          busy    <= 1'b0;
          ready   <= 1'b1;
          product <= sat_prod;
        end
      end
    end
  end

  // Caller must wait for ready before the next start
  a_no_start_busy: assert property (@(posedge CLK) disable iff (RST) busy |-> !start);

  // Completion is a one-cycle pulse
  a_ready_pulse: assert property (@(posedge CLK) disable iff (RST) ready |=> !ready);

endmodule

// ==== hw/vector_fixed_top.sv ====
`timescale 1ns/10ps

module vector_fixed_top #(
  parameter int FRAC_BITS  = 16,
  parameter int INDEX_SIZE = 8
) (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          start,
  input  logic [INDEX_SIZE-1:0]         size_in,
  input  fixed_pkg::operand_pair_t      operands,
  output logic                          ready,
  output vector_ctrl_pkg::elem_result_t elem,
  output fixed_pkg::word_t              dot_out,
  output logic                          dot_ready
);

  ////////////////////////////////////////
  // Element products
  ////////////////////////////////////////

  // Shared by the host outputs and the accumulator
  vector_fixed_multiplier #(
    .FRAC_BITS (FRAC_BITS),
    .INDEX_SIZE(INDEX_SIZE)
  ) i_vec_mul (
    .CLK     (CLK),
    .RST     (RST),
    .start   (start),
    .size_in (size_in),
    .operands(operands),
    .ready   (ready),
    .elem    (elem)
  );

  ////////////////////////////////////////
  // Dot product
  ////////////////////////////////////////

  dot_accumulator i_dot_acc (
    .CLK      (CLK),
    .RST      (RST),
    .start    (start),
    .ready    (ready),
    .elem     (elem),
    .dot_out  (dot_out),
    .dot_ready(dot_ready)
  );

endmodule

// ==== sim/tb_vector_fixed.sv ====
`timescale 1ns/10ps

module tb_vector_fixed;

  localparam int FRAC_BITS  = 16;
  localparam int INDEX_SIZE = 8;
  localparam int CLK_PERIOD = 8;
  localparam logic [31:0] SEED = 32'h2e85e9fb;

  // 40 elements at up to 40 cycles each, plus margin
  localparam int TIMEOUT_CYCLES = 40 * 40 + 400;

  ////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////

  logic                          CLK = 1'b0;
  logic                          RST;
  logic                          start;
  logic [INDEX_SIZE-1:0]         size_in;
  fixed_pkg::operand_pair_t      operands;
  logic                          ready;
  vector_ctrl_pkg::elem_result_t elem;
  fixed_pkg::word_t              dot_out;
  logic                          dot_ready;

  // Run description and expected results
  fixed_pkg::word_t vec_a    [0:15];
  fixed_pkg::word_t vec_b    [0:15];
  int unsigned      gap      [0:15];
  logic             b_first  [0:15];
  fixed_pkg::word_t exp_prod [0:15];
  fixed_pkg::word_t exp_dot  = '0;
  int               exp_len  = 0;
  int               elem_idx;

  logic  started      = 1'b0;
  string test_name    = "reset_quiet";
  int    errors       = 0;
  int    errors_begin = 0;
  int    tests_run    = 0;
  int    tests_failed = 0;
  int    cycle_cnt    = 0;

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  vector_fixed_top #(
    .FRAC_BITS (FRAC_BITS),
    .INDEX_SIZE(INDEX_SIZE)
  ) i_dut (
    .CLK      (CLK),
    .RST      (RST),
    .start    (start),
    .size_in  (size_in),
    .operands (operands),
    .ready    (ready),
    .elem     (elem),
    .dot_out  (dot_out),
    .dot_ready(dot_ready)
  );

  // Position of the next element in the run
  always @(posedge CLK or posedge RST) begin
    if (RST) begin
      elem_idx <= 0;
    end else if (start) begin
      elem_idx <= 0;
    end else if (elem.valid) begin
      elem_idx <= elem_idx + 1;
    end
  end

  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles in %s, DUT stopped responding", cycle_cnt, test_name);
      $display(">>> FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic fixed_pkg::word_t clamp(longint value);
    if (value > longint'(fixed_pkg::WORD_MAX)) begin
      return fixed_pkg::WORD_MAX;
    end
    if (value < longint'(fixed_pkg::WORD_MIN)) begin
      return fixed_pkg::WORD_MIN;
    end
    return fixed_pkg::word_t'(value);
  endfunction

  // Full product, arithmetic shift, then clamp
  function automatic fixed_pkg::word_t fixed_product(fixed_pkg::word_t a, fixed_pkg::word_t b);
    longint full;
    full = longint'(a) * longint'(b);
    return clamp(full >>> FRAC_BITS);
  endfunction

  function automatic fixed_pkg::word_t sat_add(fixed_pkg::word_t s, fixed_pkg::word_t x);
    return clamp(longint'(s) + longint'(x));
  endfunction

  task automatic report_value(string what, logic [31:0] expected, logic [31:0] actual);
    errors++;
    $display("[FAIL] %s, %s: expected %h, actual %h", test_name, what, expected, actual);
  endtask

  task automatic report_text(string msg);
    errors++;
    $display("Error in %s: %s", test_name, msg);
  endtask

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Nothing leaves the DUT before the first start
  a_quiet: assert property (@(posedge CLK) disable iff (RST)
    !started |-> !ready && !elem.valid && !dot_ready)
    else report_value("outputs before start", 32'd0,
      {29'd0, $sampled(ready), $sampled(elem.valid), $sampled(dot_ready)});

  a_product: assert property (@(posedge CLK) disable iff (RST)
    elem.valid |-> elem.data == exp_prod[elem_idx])
    else report_value("product", exp_prod[$sampled(elem_idx)], $sampled(elem.data));

  a_count: assert property (@(posedge CLK) disable iff (RST)
    elem.valid |-> elem_idx < exp_len)
    else report_text("element returned beyond the run length");

  // Last flag on the final element only
  a_last: assert property (@(posedge CLK) disable iff (RST)
    elem.valid |-> elem.last == (elem_idx == exp_len - 1))
    else report_value("last flag", 32'(($sampled(elem_idx) == exp_len - 1)),
      32'($sampled(elem.last)));

  // Ready with last and valid, or alone for an empty run
  a_ready: assert property (@(posedge CLK) disable iff (RST)
    ready || elem.last |-> ready && elem.last == (exp_len != 0) && elem.valid == (exp_len != 0))
    else report_value("ready, last, valid", {29'd0, 1'b1, {2{exp_len != 0}}},
      {29'd0, $sampled(ready), $sampled(elem.last), $sampled(elem.valid)});

  a_dot: assert property (@(posedge CLK) disable iff (RST)
    dot_ready |-> dot_out == exp_dot)
    else report_value("dot product", exp_dot, $sampled(dot_out));

  a_dot_count: assert property (@(posedge CLK) disable iff (RST)
    dot_ready |-> elem_idx == exp_len)
    else report_value("element count", exp_len, $sampled(elem_idx));

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic set_elem(int idx, fixed_pkg::word_t a, fixed_pkg::word_t b, int unsigned gp,
                          logic bf);
    vec_a[idx]   = a;
    vec_b[idx]   = b;
    gap[idx]     = gp;
    b_first[idx] = bf;
  endtask

  task automatic strobe_a(fixed_pkg::word_t value);
    operands.a    <= value;
    operands.a_en <= 1'b1;
  endtask

  task automatic strobe_b(fixed_pkg::word_t value);
    operands.b    <= value;
    operands.b_en <= 1'b1;
  endtask

  // Gap is the distance between the two strobes of one pair
  task automatic drive_pair(int idx);
    int unsigned gap_cnt;
    @(posedge CLK);
    if (gap[idx] == 0) begin
      strobe_a(vec_a[idx]);
      strobe_b(vec_b[idx]);
    end else begin
      if (b_first[idx]) strobe_b(vec_b[idx]);
      else strobe_a(vec_a[idx]);
      @(posedge CLK);
      operands.a_en <= 1'b0;
      operands.b_en <= 1'b0;
      for (gap_cnt = 1; gap_cnt < gap[idx]; gap_cnt++) begin
        @(posedge CLK);
      end
      if (b_first[idx]) strobe_a(vec_a[idx]);
      else strobe_b(vec_b[idx]);
    end
    @(posedge CLK);
    operands.a_en <= 1'b0;
    operands.b_en <= 1'b0;
  endtask

  task automatic run_vector(int len);
    int               idx;
    fixed_pkg::word_t sum;
    sum = '0;
    for (idx = 0; idx < len; idx++) begin
      exp_prod[idx] = fixed_product(vec_a[idx], vec_b[idx]);
      sum = sat_add(sum, exp_prod[idx]);
    end
    exp_len = len;
    exp_dot = sum;
    @(posedge CLK);
    start   <= 1'b1;
    size_in <= INDEX_SIZE'(len);
    started <= 1'b1;
    @(posedge CLK);
    start   <= 1'b0;
    // Length is held inside the unit from start on
    size_in <= '0;
    for (idx = 0; idx < len; idx++) begin
      drive_pair(idx);
      // Next pair only once the unit collects again
      if (idx < len - 1) begin
        do @(negedge CLK); while (!elem.valid);
      end
    end
    do @(negedge CLK); while (!dot_ready);
    // Let the checks on the final edge settle
    @(posedge CLK);
    @(negedge CLK);
  endtask

  task automatic begin_test(string name);
    test_name    = name;
    errors_begin = errors;
  endtask

  task automatic close_test();
    tests_run++;
    if (errors != errors_begin) begin
      tests_failed++;
    end
    $display("Test %s finished, %0d errors", test_name, errors - errors_begin);
  endtask

  initial begin
    int run;
    int len;
    int idx;
    void'($urandom(SEED));
    RST      = 1'b1;
    start    = 1'b0;
    size_in  = '0;
    operands = '0;
    repeat (2) @(posedge CLK);
    RST <= 1'b0;

    // Quiet outputs until the first start
    begin_test("reset_quiet");
    repeat (8) @(posedge CLK);
    close_test();

    begin_test("basic_run");
    set_elem(0, 32'sh0001_8000, 32'sh0002_0000, 0, 1'b0);
    set_elem(1, -32'sh0002_0000, 32'sh0001_8000, 0, 1'b0);
    set_elem(2, 32'sh0000_4000, -32'sh0004_0000, 0, 1'b0);
    set_elem(3, 32'sh0003_0000, -32'sh0000_8000, 0, 1'b0);
    run_vector(4);
    close_test();

    // Idle strobes with junk first, then b ahead of a
    begin_test("operand_order");
    @(posedge CLK);
    strobe_a(32'sh7fff_0000);
    strobe_b(-32'sh0123_4567);
    @(posedge CLK);
    operands.a_en <= 1'b0;
    operands.b_en <= 1'b0;
    set_elem(0, 32'sh0002_8000, -32'sh0001_0000, 2, 1'b1);
    set_elem(1, -32'sh0003_0000, -32'sh0000_8000, 3, 1'b1);
    set_elem(2, 32'sh0000_2000, 32'sh0010_0000, 1, 1'b1);
    run_vector(3);
    close_test();

    begin_test("saturation");
    set_elem(0, fixed_pkg::WORD_MAX, fixed_pkg::WORD_MAX, 0, 1'b0);
    set_elem(1, fixed_pkg::WORD_MIN, fixed_pkg::WORD_MAX, 0, 1'b0);
    set_elem(2, fixed_pkg::WORD_MIN, fixed_pkg::WORD_MIN, 0, 1'b0);
    set_elem(3, fixed_pkg::WORD_MIN, fixed_pkg::WORD_MIN, 1, 1'b1);
    run_vector(4);
    close_test();

    // Mixed signs, then an empty run
    begin_test("dot_and_empty");
    set_elem(0, 32'sh0000_8000, 32'sh0003_0000, 1, 1'b0);
    set_elem(1, -32'sh0001_4000, 32'sh0002_0000, 2, 1'b1);
    set_elem(2, 32'sh0007_0000, -32'sh0000_c000, 0, 1'b0);
    run_vector(3);
    run_vector(0);
    close_test();

    begin_test("random_runs");
    for (run = 0; run < 3; run++) begin
      len = 1 + int'($urandom % 8);
      for (idx = 0; idx < len; idx++) begin
        set_elem(idx, $signed($urandom) >>> ($urandom % 20),
          $signed($urandom) >>> ($urandom % 20), $urandom % 4, 1'($urandom % 2));
      end
      run_vector(len);
    end
    close_test();

    $display("Summary: %0d tests, %0d failing, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== vector_unit/dot_accumulator.sv ====
`timescale 1ns/10ps

module dot_accumulator (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          start,
  input  logic                          ready,
  input  vector_ctrl_pkg::elem_result_t elem,
  output fixed_pkg::word_t              dot_out,
  output logic                          dot_ready
);

  localparam int W = fixed_pkg::DATA_WIDTH;

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  fixed_pkg::word_t  sum_acc;
  logic signed [W:0] sum_wide;
  fixed_pkg::word_t  sum_sat;

  // Set between an accepted start and the result
  logic run_open;
  logic run_start;

  // Start taken when idle, or as the previous run closes
  assign run_start = start && (!run_open || ready);

  // One guard bit catches overflow
  assign sum_wide = $signed(sum_acc) + $signed(elem.data);

  always_comb begin
    if (sum_wide > fixed_pkg::WORD_MAX) begin
      sum_sat = fixed_pkg::WORD_MAX;
    end else if (sum_wide < fixed_pkg::WORD_MIN) begin
      sum_sat = fixed_pkg::WORD_MIN;
    end else begin
      sum_sat = sum_wide[W-1:0];
    end
  end

  ////////////////////////////////////////
  // Accumulate and emit
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      sum_acc   <= '0;
      dot_out   <= '0;
      dot_ready <= 1'b0;
      run_open  <= 1'b0;
    end else begin
      dot_ready <= 1'b0;
      if (elem.valid) begin
        sum_acc <= sum_sat;
        if (elem.last) begin
          dot_out   <= sum_sat;
          dot_ready <= 1'b1;
          run_open  <= 1'b0;
        end
      end else if (ready) begin
        // Empty run, sum still cleared
        dot_out   <= sum_acc;
        dot_ready <= 1'b1;
        run_open  <= 1'b0;
      end
      // New run wins over the closing one
      if (run_start) begin
        sum_acc  <= '0;
        run_open <= 1'b1;
      end
    end
  end

  a_dot_ready_pulse: assert property (@(posedge CLK) disable iff (RST)
    dot_ready |=> !dot_ready);

endmodule

// ==== vector_unit/vector_fixed_multiplier.sv ====
`timescale 1ns/10ps

module vector_fixed_multiplier #(
  parameter int FRAC_BITS  = 16,
  parameter int INDEX_SIZE = 8
) (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         start,
  input  logic [INDEX_SIZE-1:0]        size_in,
  input  fixed_pkg::operand_pair_t     operands,
  output logic                         ready,
  output vector_ctrl_pkg::elem_result_t elem
);

  localparam logic [INDEX_SIZE-1:0] ONE_IDX = INDEX_SIZE'(1);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  vector_ctrl_pkg::ctrl_state_t state;

  // Run length latched at start
  logic [INDEX_SIZE-1:0] size_len;
  logic [INDEX_SIZE-1:0] index_cnt;
  logic [INDEX_SIZE-1:0] last_idx;

  // Operands already seen for this element
  logic have_a;
  logic have_b;
  logic pair_done;

  // Scalar multiplier port
  logic             start_mul;
  fixed_pkg::word_t mul_a;
  fixed_pkg::word_t mul_b;
  logic             mul_ready;
  fixed_pkg::word_t mul_out;

  assign last_idx = size_len - ONE_IDX;

  // Pair complete once both operands seen, this cycle's strobes included
  assign pair_done = (have_a | operands.a_en) & (have_b | operands.b_en);

  ////////////////////////////////////////
  // Controller
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= vector_ctrl_pkg::ST_IDLE;
      size_len  <= '0;
      index_cnt <= '0;
      have_a    <= 1'b0;
      have_b    <= 1'b0;
      start_mul <= 1'b0;
      ready     <= 1'b0;
      elem      <= '0;
    end else begin
      // Strobes default low
      start_mul  <= 1'b0;
      ready      <= 1'b0;
      elem.valid <= 1'b0;
      elem.last  <= 1'b0;
      case (state)
        vector_ctrl_pkg::ST_IDLE: begin
          if (start) begin
            size_len  <= size_in;
            index_cnt <= '0;
            have_a    <= 1'b0;
            have_b    <= 1'b0;
            // Empty run finishes at once
            if (size_in == '0) begin
              ready <= 1'b1;
            end else begin
              state <= vector_ctrl_pkg::ST_INPUT;
            end
          end
        end
        vector_ctrl_pkg::ST_INPUT: begin
          if (pair_done) begin
            // Launch on the cycle after the second strobe
            start_mul <= 1'b1;
            have_a    <= 1'b0;
            have_b    <= 1'b0;
            state     <= vector_ctrl_pkg::ST_WAIT;
          end else begin
            have_a <= have_a | operands.a_en;
            have_b <= have_b | operands.b_en;
          end
        end
        vector_ctrl_pkg::ST_WAIT: begin
          if (mul_ready) begin
            elem.data  <= mul_out;
            elem.valid <= 1'b1;
            if (index_cnt == last_idx) begin
              elem.last <= 1'b1;
              ready     <= 1'b1;
              state     <= vector_ctrl_pkg::ST_IDLE;
            end else begin
              index_cnt <= index_cnt + ONE_IDX;
              state     <= vector_ctrl_pkg::ST_INPUT;
            end
          end
        end
        default: begin
          state <= vector_ctrl_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // Operand capture, only while collecting
  always_ff @(posedge CLK) begin
    if (state == vector_ctrl_pkg::ST_INPUT) begin
      if (operands.a_en) begin
        mul_a <= operands.a;
      end
      if (operands.b_en) begin
        mul_b <= operands.b;
      end
    end
  end

  ////////////////////////////////////////
  // Scalar multiplier
  ////////////////////////////////////////

  scalar_fixed_multiplier #(
    .FRAC_BITS(FRAC_BITS)
  ) i_scalar_mul (
    .CLK    (CLK),
    .RST    (RST),
    .start  (start_mul),
    .a      (mul_a),
    .b      (mul_b),
    .ready  (mul_ready),
    .product(mul_out)
  );

  // Results stay within the latched run length
  a_valid_in_run: assert property (@(posedge CLK) disable iff (RST)
    elem.valid |-> index_cnt < size_len);

endmodule
